// File: moving_avg_regs_pkg.sv
// Register map of the moving-average block
// Bus widths, register addresses, decode enums and reset values

`default_nettype none

package moving_avg_regs_pkg;

  //----------------------------------------------------------
  // Control bus
  //----------------------------------------------------------

  localparam int CTRL_ADDR_W = 20;
  localparam int CTRL_DATA_W = 32;

  // Byte addresses of the two registers
  localparam logic [CTRL_ADDR_W-1:0] REG_SUM_LENGTH_ADDR = CTRL_ADDR_W'(0);
  localparam logic [CTRL_ADDR_W-1:0] REG_DIVISOR_ADDR    = CTRL_ADDR_W'(4);

  // Decoded register index
  typedef enum logic [1:0] {
    REG_SUM_LENGTH = 2'd0,
    REG_DIVISOR    = 2'd1,
    REG_UNKNOWN    = 2'd3
  } reg_idx_e;

  // Bus operation seen in one cycle
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } ctrl_op_e;

  //----------------------------------------------------------
  // Register fields
  //----------------------------------------------------------

  // Window length, 1 to 255 samples
  localparam int SUM_LENGTH_W = 8;
  localparam logic [SUM_LENGTH_W-1:0] SUM_LENGTH_RESET = SUM_LENGTH_W'(10);

  // Divisor, zero never stored
  localparam int DIVISOR_W = 24;
  localparam logic [DIVISOR_W-1:0] DIVISOR_RESET = DIVISOR_W'(10);

endpackage

`default_nettype wire

// File: moving_avg_data_pkg.sv
// Datapath definitions of the moving-average block
// Sample and sum widths, history depth and divider states

`default_nettype none

package moving_avg_data_pkg;

  //----------------------------------------------------------
  // Widths
  //----------------------------------------------------------

  // Signed width of each I and Q part
  localparam int SAMPLE_W = 16;

  // History depth, also the largest window
  localparam int MAX_SUM_LENGTH = 255;
  localparam int HIST_ADDR_W    = $clog2(MAX_SUM_LENGTH);

  // Signed running sum, 255 full-scale samples fit
  localparam int SUM_W = 24;

  // Unsigned quotient magnitude before saturation
  localparam int QUOT_W = SUM_W;

  //----------------------------------------------------------
  // Divider
  //----------------------------------------------------------

  // One quotient bit per iteration
  localparam int DIV_CYCLES = 24;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_BUSY = 2'd1,
    DIV_HOLD = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// File: iq_stream_if.sv
// Stream of I/Q window sums from the running sum to the divider
// Ready/valid handshake with a last flag

`timescale 1ns/10ps
`default_nettype none

interface iq_stream_if
  import moving_avg_data_pkg::*;
();

  // Payload
  logic signed [SUM_W-1:0] sum_i;
  logic signed [SUM_W-1:0] sum_q;
  logic                    last;

  // Handshake
  logic                    valid;
  logic                    ready;

  // Sum producer
  modport src (output sum_i, output sum_q, output last, output valid, input ready);

  // Divider side
  modport snk (input sum_i, input sum_q, input last, input valid, output ready);

endinterface

`default_nettype wire

// File: moving_avg_regs.sv
// Register file of the moving-average block
// Decodes bus requests, holds sum_length and divisor, flags a window restart

`timescale 1ns/10ps
`default_nettype none

module moving_avg_regs
  import moving_avg_regs_pkg::*;
(
  input  wire                     ce_clk,
  input  wire                     rst_n,
  // Bus request
  input  wire                     ctrl_req_wr,
  input  wire                     ctrl_req_rd,
  input  wire [CTRL_ADDR_W-1:0]   ctrl_req_addr,
  input  wire [CTRL_DATA_W-1:0]   ctrl_req_data,
  // Bus response
  output logic                    ctrl_resp_ack,
  output logic [CTRL_DATA_W-1:0]  ctrl_resp_data,
  // Settings to the datapath
  output logic [SUM_LENGTH_W-1:0] sum_length,
  output logic [DIVISOR_W-1:0]    divisor,
  output logic                    clear
);

  ctrl_op_e                op;
  reg_idx_e                idx;
  logic [SUM_LENGTH_W-1:0] wr_len;
  logic [DIVISOR_W-1:0]    wr_div;

  //----------------------------------------------------------
  // Request decode
  //----------------------------------------------------------

  // Write wins if both strobes were ever high
  always_comb begin
    if (ctrl_req_wr) begin
      op = OP_WRITE;
    end else if (ctrl_req_rd) begin
      op = OP_READ;
    end else begin
      op = OP_IDLE;
    end
  end

  always_comb begin
    case (ctrl_req_addr)
      REG_SUM_LENGTH_ADDR: idx = REG_SUM_LENGTH;
      REG_DIVISOR_ADDR:    idx = REG_DIVISOR;
      default:             idx = REG_UNKNOWN;
    endcase
  end

  // Fields taken from the low bits of the write data
  assign wr_len = ctrl_req_data[SUM_LENGTH_W-1:0];
  assign wr_div = ctrl_req_data[DIVISOR_W-1:0];

  //----------------------------------------------------------
  // Registers and response
  //----------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (!rst_n) begin
      sum_length     <= SUM_LENGTH_RESET;
      divisor        <= DIVISOR_RESET;
      ctrl_resp_ack  <= 1'b0;
      ctrl_resp_data <= '0;
      clear          <= 1'b0;
    end else begin
      // Ack one cycle after any request
      ctrl_resp_ack  <= (op != OP_IDLE);
      ctrl_resp_data <= '0;
      clear          <= 1'b0;
      case (op)
        OP_WRITE: begin
          // Zero values are dropped
          if (idx == REG_SUM_LENGTH && wr_len != '0) begin
            sum_length <= wr_len;
            // New length restarts the window
            clear      <= 1'b1;
          end
          if (idx == REG_DIVISOR && wr_div != '0) begin
            divisor <= wr_div;
          end
        end
        OP_READ: begin
          case (idx)
            REG_SUM_LENGTH: ctrl_resp_data <= CTRL_DATA_W'(sum_length);
            REG_DIVISOR:    ctrl_resp_data <= CTRL_DATA_W'(divisor);
            default:        ctrl_resp_data <= '0;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: moving_avg_sum.sv
// Running sum stage of the moving-average block
// Keeps the sample history and the I and Q window sums

`timescale 1ns/10ps
`default_nettype none

module moving_avg_sum
  import moving_avg_data_pkg::*;
  import moving_avg_regs_pkg::*;
(
  input  wire                       ce_clk,
  input  wire                       rst_n,
  // Input sample stream
  input  wire signed [SAMPLE_W-1:0] in_i,
  input  wire signed [SAMPLE_W-1:0] in_q,
  input  wire                       in_last,
  input  wire                       in_valid,
  output logic                      in_ready,
  // Settings
  input  wire [SUM_LENGTH_W-1:0]    sum_length,
  input  wire                       clear,
  // Sums to the divider
  iq_stream_if.src                  sums
);

  localparam logic [HIST_ADDR_W:0]   HIST_DEPTH = (HIST_ADDR_W + 1)'(MAX_SUM_LENGTH);
  localparam logic [HIST_ADDR_W-1:0] FILL_MAX   = HIST_ADDR_W'(MAX_SUM_LENGTH);

  // Packed {I, Q} history, circular over 255 entries
  logic [2*SAMPLE_W-1:0]   hist [MAX_SUM_LENGTH];
  logic [HIST_ADDR_W-1:0]  wr_ptr;
  logic [HIST_ADDR_W-1:0]  rd_ptr;
  logic [HIST_ADDR_W:0]    rd_raw;
  logic [HIST_ADDR_W:0]    rd_fix;
  logic [HIST_ADDR_W-1:0]  fill;
  logic [HIST_ADDR_W-1:0]  fill_base;
  logic                    accept;

  logic signed [SUM_W-1:0]    acc_i, acc_q;
  logic signed [SUM_W-1:0]    base_i, base_q;
  logic signed [SUM_W-1:0]    old_i, old_q;
  logic signed [SUM_W-1:0]    next_i, next_q;
  logic signed [SAMPLE_W-1:0] drop_i, drop_q;

  // One-deep output register, refilled while it drains
  assign in_ready = !sums.valid || sums.ready;
  assign accept   = in_valid && in_ready;

  //----------------------------------------------------------
  // Window arithmetic
  //----------------------------------------------------------

  // Entry sum_length places behind the write pointer, modulo 255
  assign rd_raw = {1'b0, wr_ptr} + HIST_DEPTH - {1'b0, sum_length};
  assign rd_fix = (rd_raw >= HIST_DEPTH) ? rd_raw - HIST_DEPTH : rd_raw;
  assign rd_ptr = rd_fix[HIST_ADDR_W-1:0];

  assign drop_i = hist[rd_ptr][2*SAMPLE_W-1:SAMPLE_W];
  assign drop_q = hist[rd_ptr][SAMPLE_W-1:0];

  always_comb begin
    // A clear in the same cycle makes this sample the first of a new window
    fill_base = clear ? '0 : fill;
    base_i    = clear ? '0 : acc_i;
    base_q    = clear ? '0 : acc_q;
    // Samples older than the history count as zero
    if (fill_base >= sum_length) begin
      old_i = drop_i;
      old_q = drop_q;
    end else begin
      old_i = '0;
      old_q = '0;
    end
    next_i = base_i + in_i - old_i;
    next_q = base_q + in_q - old_q;
  end

  //----------------------------------------------------------
  // State
  //----------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      fill       <= '0;
      acc_i      <= '0;
      acc_q      <= '0;
      sums.valid <= 1'b0;
    end else begin
      if (accept) begin
        acc_i      <= next_i;
        acc_q      <= next_q;
        wr_ptr     <= (wr_ptr == FILL_MAX - 1'b1) ? '0 : wr_ptr + 1'b1;
        fill       <= (fill_base == FILL_MAX) ? fill_base : fill_base + 1'b1;
        sums.valid <= 1'b1;
      end else begin
        if (clear) begin
          acc_i <= '0;
          acc_q <= '0;
          fill  <= '0;
        end
        if (sums.ready) begin
          sums.valid <= 1'b0;
        end
      end
    end
  end

  // History and outgoing payload
  always_ff @(posedge ce_clk) begin
    if (accept) begin
      hist[wr_ptr] <= {in_i, in_q};
      sums.sum_i   <= next_i;
      sums.sum_q   <= next_q;
      sums.last    <= in_last;
    end
  end

endmodule

`default_nettype wire

// File: moving_avg_divide.sv
// Divider stage of the moving-average block
// Restoring divide of both sums, sign restore, saturation and output register

`timescale 1ns/10ps
`default_nettype none

module moving_avg_divide
  import moving_avg_data_pkg::*;
  import moving_avg_regs_pkg::*;
(
  input  wire                        ce_clk,
  input  wire                        rst_n,
  iq_stream_if.snk                   sums,
  input  wire [DIVISOR_W-1:0]        divisor,
  // Averaged output stream
  output logic signed [SAMPLE_W-1:0] out_i,
  output logic signed [SAMPLE_W-1:0] out_q,
  output logic                       out_last,
  output logic                       out_valid,
  input  wire                        out_ready
);

  localparam int                CNT_W     = $clog2(DIV_CYCLES);
  localparam logic [CNT_W-1:0]  LAST_ITER = CNT_W'(DIV_CYCLES - 1);
  localparam logic [QUOT_W-1:0] POS_LIMIT = QUOT_W'(2**(SAMPLE_W-1) - 1);
  localparam logic [QUOT_W-1:0] NEG_LIMIT = QUOT_W'(2**(SAMPLE_W-1));

  div_state_e                    state;
  logic [CNT_W-1:0]              cnt;
  logic [DIVISOR_W-1:0]          dvsr;
  logic [DIVISOR_W-1:0]          rem_i, rem_q;
  logic [QUOT_W-1:0]             quo_i, quo_q;
  logic [QUOT_W-1:0]             abs_i, abs_q;
  logic [QUOT_W-1:0]             fin_i, fin_q;
  logic [DIVISOR_W+QUOT_W-1:0]   step_i, step_q;
  logic                          neg_i, neg_q, last_r;
  logic                          out_free, done;

  // One restoring step, dividend bits shift out as quotient bits shift in
  function automatic logic [DIVISOR_W+QUOT_W-1:0] div_step(
    input logic [DIVISOR_W-1:0] rem,
    input logic [QUOT_W-1:0]    quo,
    input logic [DIVISOR_W-1:0] dvs
  );
    logic [DIVISOR_W:0] trial;
    logic [DIVISOR_W:0] diff;
    trial = {rem, quo[QUOT_W-1]};
    diff  = trial - {1'b0, dvs};
    if (trial >= {1'b0, dvs}) begin
      return {diff[DIVISOR_W-1:0], quo[QUOT_W-2:0], 1'b1};
    end
    return {trial[DIVISOR_W-1:0], quo[QUOT_W-2:0], 1'b0};
  endfunction

  // Apply the sign, then clamp to the 16-bit signed range
  function automatic logic signed [SAMPLE_W-1:0] sat_sign(
    input logic [QUOT_W-1:0] mag,
    input logic              neg
  );
    logic signed [SAMPLE_W-1:0] res;
    if (neg) begin
      if (mag > NEG_LIMIT) begin
        res = {1'b1, {(SAMPLE_W-1){1'b0}}};
      end else begin
        res = -signed'(mag[SAMPLE_W-1:0]);
      end
    end else if (mag > POS_LIMIT) begin
      res = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end else begin
      res = signed'(mag[SAMPLE_W-1:0]);
    end
    return res;
  endfunction

  //----------------------------------------------------------
  // Datapath
  //----------------------------------------------------------

  // Magnitudes, truncation toward zero comes from dividing these
  assign abs_i = sums.sum_i[SUM_W-1] ? -sums.sum_i : sums.sum_i;
  assign abs_q = sums.sum_q[SUM_W-1] ? -sums.sum_q : sums.sum_q;

  assign step_i = div_step(rem_i, quo_i, dvsr);
  assign step_q = div_step(rem_q, quo_q, dvsr);

  // Last iteration hands its quotient straight to the output
  assign fin_i = (state == DIV_BUSY) ? step_i[QUOT_W-1:0] : quo_i;
  assign fin_q = (state == DIV_BUSY) ? step_q[QUOT_W-1:0] : quo_q;

  assign sums.ready = (state == DIV_IDLE);
  assign out_free   = !out_valid || out_ready;
  assign done       = (state == DIV_BUSY && cnt == LAST_ITER) || state == DIV_HOLD;

  //----------------------------------------------------------
  // Control FSM
  //----------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (!rst_n) begin
      state     <= DIV_IDLE;
      cnt       <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      case (state)
        DIV_IDLE: begin
          if (sums.valid) begin
            state <= DIV_BUSY;
            cnt   <= '0;
          end
        end
        DIV_BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == LAST_ITER) begin
            state <= out_free ? DIV_IDLE : DIV_HOLD;
          end
        end
        DIV_HOLD: begin
          if (out_free) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
      if (done && out_free) begin
        out_valid <= 1'b1;
      end
    end
  end

  // Working registers and output payload
  always_ff @(posedge ce_clk) begin
    if (state == DIV_IDLE && sums.valid) begin
      rem_i  <= '0;
      rem_q  <= '0;
      quo_i  <= abs_i;
      quo_q  <= abs_q;
      neg_i  <= sums.sum_i[SUM_W-1];
      neg_q  <= sums.sum_q[SUM_W-1];
      // Divisor captured per item so a later write cannot disturb it
      dvsr   <= divisor;
      last_r <= sums.last;
    end else if (state == DIV_BUSY) begin
      rem_i <= step_i[DIVISOR_W+QUOT_W-1 -: DIVISOR_W];
      rem_q <= step_q[DIVISOR_W+QUOT_W-1 -: DIVISOR_W];
      quo_i <= step_i[QUOT_W-1:0];
      quo_q <= step_q[QUOT_W-1:0];
    end
    if (done && out_free) begin
      out_i    <= sat_sign(fin_i, neg_i);
      out_q    <= sat_sign(fin_q, neg_q);
      out_last <= last_r;
    end
  end

endmodule

`default_nettype wire

// File: moving_avg_block.sv
// Moving-average block for a complex I/Q stream
// Register file, running sum and divider joined under one clock

`timescale 1ns/10ps
`default_nettype none

module moving_avg_block
  import moving_avg_regs_pkg::*;
  import moving_avg_data_pkg::*;
(
  input  wire                        ce_clk,
  input  wire                        rst_n,
  // Control bus
  input  wire                        ctrl_req_wr,
  input  wire                        ctrl_req_rd,
  input  wire [CTRL_ADDR_W-1:0]      ctrl_req_addr,
  input  wire [CTRL_DATA_W-1:0]      ctrl_req_data,
  output wire                        ctrl_resp_ack,
  output wire [CTRL_DATA_W-1:0]      ctrl_resp_data,
  // Input stream
  input  wire signed [SAMPLE_W-1:0]  in_i,
  input  wire signed [SAMPLE_W-1:0]  in_q,
  input  wire                        in_last,
  input  wire                        in_valid,
  output wire                        in_ready,
  // Output stream
  output wire signed [SAMPLE_W-1:0]  out_i,
  output wire signed [SAMPLE_W-1:0]  out_q,
  output wire                        out_last,
  output wire                        out_valid,
  input  wire                        out_ready
);

  //----------------------------------------------------------
  // Settings and sum stream
  //----------------------------------------------------------

  logic [SUM_LENGTH_W-1:0] sum_length;
  logic [DIVISOR_W-1:0]    divisor;
  logic                    clear;

  iq_stream_if sums ();

  //----------------------------------------------------------
  // Stages
  //----------------------------------------------------------

  // Decode
  moving_avg_regs regs_i (
    .ce_clk         (ce_clk),
    .rst_n          (rst_n),
    .ctrl_req_wr    (ctrl_req_wr),
    .ctrl_req_rd    (ctrl_req_rd),
    .ctrl_req_addr  (ctrl_req_addr),
    .ctrl_req_data  (ctrl_req_data),
    .ctrl_resp_ack  (ctrl_resp_ack),
    .ctrl_resp_data (ctrl_resp_data),
    .sum_length     (sum_length),
    .divisor        (divisor),
    .clear          (clear)
  );

  // Running sum
  moving_avg_sum sum_i (
    .ce_clk     (ce_clk),
    .rst_n      (rst_n),
    .in_i       (in_i),
    .in_q       (in_q),
    .in_last    (in_last),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .sum_length (sum_length),
    .clear      (clear),
    .sums       (sums.src)
  );

  // Divide and output
  moving_avg_divide divide_i (
    .ce_clk    (ce_clk),
    .rst_n     (rst_n),
    .sums      (sums.snk),
    .divisor   (divisor),
    .out_i     (out_i),
    .out_q     (out_q),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: moving_avg_sva.sv
// Protocol assertions for the moving-average block
// Bus acknowledge timing and output stream stability

`timescale 1ns/10ps
`default_nettype none

module moving_avg_sva
  import moving_avg_data_pkg::*;
(
  input wire                       ce_clk,
  input wire                       rst_n,
  input wire                       ctrl_req_wr,
  input wire                       ctrl_req_rd,
  input wire                       ctrl_resp_ack,
  input wire signed [SAMPLE_W-1:0] out_i,
  input wire signed [SAMPLE_W-1:0] out_q,
  input wire                       out_last,
  input wire                       out_valid,
  input wire                       out_ready
);

  //------------------------------------------------------------
  // Control bus
  //------------------------------------------------------------

  // Every request answered on the next cycle
  ack_after_request: assert property (@(posedge ce_clk) disable iff (!rst_n)
    (ctrl_req_wr || ctrl_req_rd) |=> ctrl_resp_ack)
    else $error("ctrl_resp_ack missing one cycle after a request");

  // Only one strobe per request
  single_strobe: assert property (@(posedge ce_clk) disable iff (!rst_n)
    !(ctrl_req_wr && ctrl_req_rd))
    else $error("ctrl_req_wr and ctrl_req_rd high together");

  // An ack always has a request behind it
  no_stray_ack: assert property (@(posedge ce_clk) disable iff (!rst_n)
    ctrl_resp_ack |-> $past(ctrl_req_wr || ctrl_req_rd))
    else $error("ctrl_resp_ack without a request");

  //------------------------------------------------------------
  // Output stream
  //------------------------------------------------------------

  // Held payload while the sink stalls
  out_stable: assert property (@(posedge ce_clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_i) && $stable(out_q) && $stable(out_last)))
    else $error("output stream changed while stalled");

endmodule

bind moving_avg_block moving_avg_sva sva_i (
  .ce_clk        (ce_clk),
  .rst_n         (rst_n),
  .ctrl_req_wr   (ctrl_req_wr),
  .ctrl_req_rd   (ctrl_req_rd),
  .ctrl_resp_ack (ctrl_resp_ack),
  .out_i         (out_i),
  .out_q         (out_q),
  .out_last      (out_last),
  .out_valid     (out_valid),
  .out_ready     (out_ready)
);

`default_nettype wire

// File: tb_moving_avg.sv
// Testbench for the moving-average block
// Table-driven register and stream steps checked against a window model

`timescale 1ns/10ps
`default_nettype none

module tb_moving_avg
  import moving_avg_regs_pkg::*;
  import moving_avg_data_pkg::*;
();

  localparam int NUM_ROWS     = 29;
  localparam int ACK_TIMEOUT  = 20;
  localparam int IN_TIMEOUT   = 400;
  localparam int OUT_TIMEOUT  = 400;
  localparam int QUIET_CYCLES = 60;

  typedef enum int {ROW_WRITE, ROW_READ, ROW_BURST, ROW_STALL} row_op_e;

  // Burst rows use arg as sample count and data as sample mode
  typedef struct {
    row_op_e op;
    int      arg;
    int      data;
    int      exp_val;
  } step_t;

  logic                       ce_clk, rst_n;
  logic                       ctrl_req_wr, ctrl_req_rd;
  logic [CTRL_ADDR_W-1:0]     ctrl_req_addr;
  logic [CTRL_DATA_W-1:0]     ctrl_req_data;
  logic                       ctrl_resp_ack;
  logic [CTRL_DATA_W-1:0]     ctrl_resp_data;
  logic signed [SAMPLE_W-1:0] in_i, in_q, out_i, out_q;
  logic                       in_last, in_valid, in_ready;
  logic                       out_last, out_valid, out_ready;

  step_t                      rows [NUM_ROWS];
  int                         seed;
  // Model window contents since the last restart
  int                         hist_i[$], hist_q[$];
  int                         model_len, model_div;
  logic signed [SAMPLE_W-1:0] exp_i[$], exp_q[$];
  logic                       exp_last[$];

  moving_avg_block UUT (.*);

  always #4 ce_clk = ~ce_clk;

  task automatic report_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  //------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------

  // Sum of the newest model_len samples with missing ones as zero
  function automatic int window_avg(input bit use_q);
    int sum;
    int n;
    int k;
    int quo;
    sum = 0;
    n   = (hist_i.size() < model_len) ? hist_i.size() : model_len;
    for (k = 0; k < n; k++) begin
      sum += use_q ? hist_q[hist_q.size()-1-k] : hist_i[hist_i.size()-1-k];
    end
    // Integer divide truncates toward zero
    quo = sum / model_div;
    if (quo > 32767) begin
      quo = 32767;
    end else if (quo < -32768) begin
      quo = -32768;
    end
    return quo;
  endfunction

  task automatic record_sample(input logic signed [SAMPLE_W-1:0] si,
                               input logic signed [SAMPLE_W-1:0] sq, input logic sl);
    hist_i.push_back(int'(si));
    hist_q.push_back(int'(sq));
    if (hist_i.size() > MAX_SUM_LENGTH) begin
      void'(hist_i.pop_front());
      void'(hist_q.pop_front());
    end
    exp_i.push_back(16'(window_avg(1'b0)));
    exp_q.push_back(16'(window_avg(1'b1)));
    exp_last.push_back(sl);
  endtask

  // Mode 0 full range, 1 large positive, 2 large negative, 3 small mixed
  function automatic logic signed [SAMPLE_W-1:0] make_sample(input int mode);
    int r;
    r = $random(seed);
    case (mode)
      1:       return 16'(16384 + (r & 16'h3fff));
      2:       return 16'(-32768 + (r & 16'h3fff));
      3:       return 16'(r % 50);
      default: return r[15:0];
    endcase
  endfunction

  //------------------------------------------------------------
  // Register bus
  //------------------------------------------------------------

  task automatic access_register(input bit is_write, input int addr, input int data,
                                 input int exp_val);
    int cycles;
    @(negedge ce_clk);
    ctrl_req_wr   = is_write;
    ctrl_req_rd   = !is_write;
    ctrl_req_addr = addr[CTRL_ADDR_W-1:0];
    ctrl_req_data = data;
    @(negedge ce_clk);
    ctrl_req_wr = 1'b0;
    ctrl_req_rd = 1'b0;
    cycles      = 1;
    while (!ctrl_resp_ack) begin
      assert (cycles < ACK_TIMEOUT) else begin
        $display("Timeout waiting for ctrl_resp_ack");
        report_failure();
      end
      @(negedge ce_clk);
      cycles++;
    end
    assert (cycles == 1) else begin
      $display("[ERROR] ctrl_resp_ack latency got %h expected %h", cycles, 1);
      report_failure();
    end
    if (!is_write) begin
      assert (ctrl_resp_data === 32'(exp_val)) else begin
        $display("[ERROR] ctrl_resp_data got %h expected %h", ctrl_resp_data, exp_val);
        report_failure();
      end
    end else if (addr == 0 && (data & 8'hff) != 0) begin
      // New length restarts the window
      model_len = data & 8'hff;
      hist_i.delete();
      hist_q.delete();
    end else if (addr == 4 && (data & 24'hffffff) != 0) begin
      model_div = data & 24'hffffff;
    end
  endtask

  //------------------------------------------------------------
  // Sample stream
  //------------------------------------------------------------

  task automatic send_samples(input int count, input int mode);
    int                         n;
    int                         wait_cycles;
    logic signed [SAMPLE_W-1:0] si, sq;
    logic                       sl;
    for (n = 0; n < count; n++) begin
      @(negedge ce_clk);
      si       = make_sample(mode);
      sq       = make_sample(mode);
      sl       = ($random(seed) & 1) != 0;
      in_i     = si;
      in_q     = sq;
      in_last  = sl;
      in_valid = 1'b1;
      wait_cycles = 0;
      // Accepted on the next rising edge once in_ready is high here
      while (!in_ready) begin
        @(negedge ce_clk);
        wait_cycles++;
        assert (wait_cycles < IN_TIMEOUT) else begin
          $display("Timeout waiting for in_ready");
          report_failure();
        end
      end
      record_sample(si, sq, sl);
    end
    @(negedge ce_clk);
    in_valid = 1'b0;
  endtask

  task automatic check_output();
    logic signed [SAMPLE_W-1:0] ei, eq;
    logic                       el;
    assert (exp_i.size() > 0) else begin
      $display("Output arrived with no sample pending");
      report_failure();
    end
    ei = exp_i.pop_front();
    eq = exp_q.pop_front();
    el = exp_last.pop_front();
    assert (out_i === ei) else begin
      $display("[ERROR] out_i got %h expected %h", out_i, ei);
      report_failure();
    end
    assert (out_q === eq) else begin
      $display("[ERROR] out_q got %h expected %h", out_q, eq);
      report_failure();
    end
    assert (out_last === el) else begin
      $display("[ERROR] out_last got %h expected %h", out_last, el);
      report_failure();
    end
  endtask

  task automatic collect_outputs(input int count, input bit stall);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while (got < count) begin
      @(negedge ce_clk);
      out_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
      if (out_valid && out_ready) begin
        check_output();
        got++;
        idle = 0;
      end else begin
        idle++;
        assert (idle < OUT_TIMEOUT) else begin
          $display("Timeout waiting for out_valid");
          report_failure();
        end
      end
    end
  endtask

  task automatic run_burst(input int count, input int mode, input bit stall);
    int quiet;
    fork
      send_samples(count, mode);
      collect_outputs(count, stall);
    join
    // No output beyond the expected ones while the pipeline drains
    for (quiet = 0; quiet < QUIET_CYCLES; quiet++) begin
      @(negedge ce_clk);
      out_ready = 1'b1;
      assert (!out_valid) else begin
        $display("Extra output after a burst");
        report_failure();
      end
    end
  endtask

  //------------------------------------------------------------
  // Stimulus table
  //------------------------------------------------------------

  task automatic fill_table();
    rows[0]  = '{ROW_READ,  0,     0,   10};
    rows[1]  = '{ROW_READ,  4,     0,   10};
    rows[2]  = '{ROW_READ,  'h10,  0,   0};
    rows[3]  = '{ROW_BURST, 30,    0,   0};
    rows[4]  = '{ROW_WRITE, 4,     3,   0};
    rows[5]  = '{ROW_READ,  4,     0,   3};
    rows[6]  = '{ROW_WRITE, 4,     0,   0};
    rows[7]  = '{ROW_READ,  4,     0,   3};
    rows[8]  = '{ROW_WRITE, 0,     0,   0};
    rows[9]  = '{ROW_READ,  0,     0,   10};
    rows[10] = '{ROW_BURST, 25,    0,   0};
    rows[11] = '{ROW_WRITE, 0,     1,   0};
    rows[12] = '{ROW_READ,  0,     0,   1};
    rows[13] = '{ROW_BURST, 12,    0,   0};
    rows[14] = '{ROW_WRITE, 0,     255, 0};
    rows[15] = '{ROW_READ,  0,     0,   255};
    rows[16] = '{ROW_BURST, 300,   0,   0};
    // Divisor 1 with large samples drives the clamp
    rows[17] = '{ROW_WRITE, 4,     1,   0};
    rows[18] = '{ROW_WRITE, 0,     4,   0};
    rows[19] = '{ROW_BURST, 12,    1,   0};
    rows[20] = '{ROW_BURST, 12,    2,   0};
    rows[21] = '{ROW_WRITE, 4,     7,   0};
    rows[22] = '{ROW_WRITE, 0,     16,  0};
    rows[23] = '{ROW_BURST, 40,    3,   0};
    rows[24] = '{ROW_STALL, 80,    0,   0};
    rows[25] = '{ROW_WRITE, 8,     55,  0};
    rows[26] = '{ROW_READ,  0,     0,   16};
    rows[27] = '{ROW_READ,  4,     0,   7};
    rows[28] = '{ROW_READ,  8,     0,   0};
  endtask

  initial begin
    int r;
    seed          = 32'h7372a322;
    ce_clk        = 1'b0;
    rst_n         = 1'b0;
    ctrl_req_wr   = 1'b0;
    ctrl_req_rd   = 1'b0;
    ctrl_req_addr = '0;
    ctrl_req_data = '0;
    in_i          = '0;
    in_q          = '0;
    in_last       = 1'b0;
    in_valid      = 1'b0;
    out_ready     = 1'b1;
    model_len     = 10;
    model_div     = 10;
    fill_table();
    repeat (10) @(negedge ce_clk);
    rst_n = 1'b1;
    for (r = 0; r < NUM_ROWS; r++) begin
      case (rows[r].op)
        ROW_WRITE: access_register(1'b1, rows[r].arg, rows[r].data, rows[r].exp_val);
        ROW_READ:  access_register(1'b0, rows[r].arg, rows[r].data, rows[r].exp_val);
        ROW_BURST: run_burst(rows[r].arg, rows[r].data, 1'b0);
        default:   run_burst(rows[r].arg, rows[r].data, 1'b1);
      endcase
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
moving_avg_regs_pkg.sv
moving_avg_data_pkg.sv
iq_stream_if.sv
moving_avg_regs.sv
moving_avg_sum.sv
moving_avg_divide.sv
moving_avg_block.sv
moving_avg_sva.sv
tb_moving_avg.sv

// File: run.sh
#!/bin/sh
# Compile and run the moving-average testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_moving_avg
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi
out=$(./obj_dir/Vtb_moving_avg)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  exit 1
fi
if printf '%s\n' "$out" | grep -q "Result: PASSED"; then
  exit 0
fi
exit 1
